/* soc_mem_config.svh */
// Bus widths, memory depths, region tags and exit address macros
`ifndef SOC_MEM_CONFIG_SVH
`define SOC_MEM_CONFIG_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_STRB_W 8

// Storage depths in 64-bit words
`define SOC_SRAM_WORDS 1024
`define SOC_ROM_WORDS 16

// Region tags, compared against address bits 31..16
`define SOC_DRAM_TAG 16'h8000
`define SOC_ROM_TAG 16'h0001

// Last SRAM word doubles as the simulation exit register
`define SOC_EXIT_ADDR 32'h8000_1FF8

`endif

/* soc_mem_pkg.sv */
// Package with data and strobe types, address union and region enumeration
`include "soc_mem_config.svh"

package soc_mem_pkg;

  typedef logic [`SOC_DATA_W-1:0] data_t;
  typedef logic [`SOC_STRB_W-1:0] strb_t;

  // ----------------------------------------
  // Address, seen as one word or as fields
  // ----------------------------------------
  typedef struct packed {
    logic [15:0] tag;
    logic [12:0] word;
    logic [2:0]  offset;
  } bus_addr_fields_t;

  typedef union packed {
    logic [`SOC_ADDR_W-1:0] raw;
    bus_addr_fields_t       fields;
  } bus_addr_u;

  // Target of a request, kept for the answer
  typedef enum logic [1:0] {
    REGION_NONE = 2'd0,
    REGION_DRAM = 2'd1,
    REGION_ROM  = 2'd2
  } region_e;

endpackage

/* addr_decoder.sv */
// Address decoder: region selects, registered answer region and exit detection
`include "soc_mem_config.svh"

module addr_decoder
  import soc_mem_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic        we_i,
  input  bus_addr_u   addr_i,
  input  data_t       wdata_i,
  output logic        sram_sel_o,
  output logic        rom_sel_o,
  output logic        rsp_valid_o,
  output region_e     rsp_region_o,
  output logic        rsp_write_o,
  output logic [31:0] exit_o
);

  region_e region_d;
  logic    exit_hit;

  // ----------------------------------------
  // Region decode on the tag field
  // ----------------------------------------
  always_comb begin
    case (addr_i.fields.tag)
      `SOC_DRAM_TAG: region_d = REGION_DRAM;
      `SOC_ROM_TAG:  region_d = REGION_ROM;
      default:       region_d = REGION_NONE;
    endcase
  end

  // Strobes only while a request is on the bus
  assign sram_sel_o = req_i & (region_d == REGION_DRAM);
  assign rom_sel_o  = req_i & (region_d == REGION_ROM);

  // ----------------------------------------
  // Answer bookkeeping, one cycle later
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o  <= 1'b0;
      rsp_region_o <= REGION_NONE;
      rsp_write_o  <= 1'b0;
    end else begin
      rsp_valid_o  <= req_i;
      rsp_region_o <= req_i ? region_d : REGION_NONE;
      rsp_write_o  <= req_i & we_i;
    end
  end

  // Exit register, raw address compare
  // The write itself still goes to the SRAM through sram_sel_o
  assign exit_hit = req_i & we_i & (addr_i.raw == `SOC_EXIT_ADDR);
  assign exit_o   = exit_hit ? wdata_i[31:0] : 32'h0;

endmodule

/* sram_bank.sv */
// Single-port SRAM with byte-enable writes and registered read
`include "soc_mem_config.svh"

module sram_bank
  import soc_mem_pkg::*;
#(
  parameter int unsigned NUM_WORDS = `SOC_SRAM_WORDS
) (
  input  logic                         clk_i,
  input  logic                         sel_i,
  input  logic                         we_i,
  input  logic [$clog2(NUM_WORDS)-1:0] word_i,
  input  strb_t                        be_i,
  input  data_t                        wdata_i,
  output data_t                        rdata_o
);

  // Storage array, contents undefined after power-up
  data_t mem_q [NUM_WORDS];

  // ----------------------------------------
  // Byte-masked write port
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (sel_i && we_i) begin
      for (int b = 0; b < `SOC_STRB_W; b++) begin
        if (be_i[b]) begin
          mem_q[word_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // Read port, one cycle latency
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (sel_i && !we_i) begin
      rdata_o <= mem_q[word_i];
    end
  end

endmodule

/* boot_rom.sv */
// Boot ROM with sixteen generated words and a registered read
`include "soc_mem_config.svh"

module boot_rom
  import soc_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       sel_i,
  input  logic [3:0] word_i,
  output data_t      rdata_o
);

  data_t rom_table [`SOC_ROM_WORDS];

  // Upper half counts up from B007_0000 and lower half is its inverse
  for (genvar i = 0; i < `SOC_ROM_WORDS; i++) begin : gen_rom_word
    localparam logic [31:0] upper_word = 32'hB007_0000 + 32'(i);
    assign rom_table[i] = {upper_word, ~upper_word};
  end

  // Writes also register a word that the response mux drops
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= rom_table[word_i];
    end
  end

endmodule

/* bus_response_mux.sv */
// Response combiner: SRAM and ROM read data plus decode-error answer
module bus_response_mux
  import soc_mem_pkg::*;
(
  input  logic    rsp_valid_i,
  input  region_e rsp_region_i,
  input  logic    rsp_write_i,
  input  data_t   sram_rdata_i,
  input  data_t   rom_rdata_i,
  output logic    rsp_valid_o,
  output data_t   rdata_o,
  output logic    err_o
);

  data_t region_rdata;

  // ----------------------------------------
  // Read word by registered region
  // ----------------------------------------
  always_comb begin
    case (rsp_region_i)
      REGION_DRAM: region_rdata = sram_rdata_i;
      REGION_ROM:  region_rdata = rom_rdata_i;
      default:     region_rdata = '0;
    endcase
  end

  // Write answers and error answers carry no data
  always_comb begin
    if (rsp_valid_i && !rsp_write_i) begin
      rdata_o = region_rdata;
    end else begin
      rdata_o = '0;
    end
  end

  // Decode error, like an error slave on an unmapped window
  assign err_o       = rsp_valid_i & (rsp_region_i == REGION_NONE);
  assign rsp_valid_o = rsp_valid_i;

endmodule

/* soc_mem_top.sv */
// Memory subsystem top: decoder, SRAM bank, boot ROM and response mux
`include "soc_mem_config.svh"

module soc_mem_top
  import soc_mem_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic        we_i,
  input  bus_addr_u   addr_i,
  input  strb_t       be_i,
  input  data_t       wdata_i,
  output logic        rsp_valid_o,
  output data_t       rdata_o,
  output logic        err_o,
  output logic [31:0] exit_o
);

  logic    sram_sel;
  logic    rom_sel;
  logic    rsp_valid;
  region_e rsp_region;
  logic    rsp_write;
  data_t   sram_rdata;
  data_t   rom_rdata;

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  addr_decoder addr_decoder_inst (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .req_i        ( req_i      ),
    .we_i         ( we_i       ),
    .addr_i       ( addr_i     ),
    .wdata_i      ( wdata_i    ),
    .sram_sel_o   ( sram_sel   ),
    .rom_sel_o    ( rom_sel    ),
    .rsp_valid_o  ( rsp_valid  ),
    .rsp_region_o ( rsp_region ),
    .rsp_write_o  ( rsp_write  ),
    .exit_o       ( exit_o     )
  );

  // Low word-index bits only, so the region wraps
  sram_bank #(
    .NUM_WORDS ( `SOC_SRAM_WORDS )
  ) sram_bank_inst (
    .clk_i   ( clk_i                                                ),
    .sel_i   ( sram_sel                                             ),
    .we_i    ( we_i                                                 ),
    .word_i  ( addr_i.fields.word[$clog2(`SOC_SRAM_WORDS)-1:0]      ),
    .be_i    ( be_i                                                 ),
    .wdata_i ( wdata_i                                              ),
    .rdata_o ( sram_rdata                                           )
  );

  boot_rom boot_rom_inst (
    .clk_i   ( clk_i                   ),
    .sel_i   ( rom_sel                 ),
    .word_i  ( addr_i.fields.word[3:0] ),
    .rdata_o ( rom_rdata               )
  );

  // ----------------------------------------
  // Response side
  // ----------------------------------------
  bus_response_mux bus_response_mux_inst (
    .rsp_valid_i  ( rsp_valid   ),
    .rsp_region_i ( rsp_region  ),
    .rsp_write_i  ( rsp_write   ),
    .sram_rdata_i ( sram_rdata  ),
    .rom_rdata_i  ( rom_rdata   ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rdata_o      ( rdata_o     ),
    .err_o        ( err_o       )
  );

endmodule

/* soc_mem_props.sv */
// Bound assertions on the memory top: answer timing, error data and exit value
`include "soc_mem_config.svh"

module soc_mem_props
  import soc_mem_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input logic        req_i,
  input logic        we_i,
  input bus_addr_u   addr_i,
  input logic        rsp_valid_i,
  input data_t       rdata_i,
  input logic        err_i,
  input logic [31:0] exit_i
);

  int unsigned assert_fails = 0;

  // Every request answered exactly one cycle later
  valid_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i == $past(req_i))
    else begin
      assert_fails++;
      $error("rsp_valid_o does not follow req_i by one cycle");
    end

  err_zero_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_i |-> (rdata_i == '0))
    else begin
      assert_fails++;
      $error("err_o with nonzero rdata_o");
    end

  exit_only_on_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (exit_i != 32'h0) |-> (req_i && we_i && addr_i.raw == `SOC_EXIT_ADDR))
    else begin
      assert_fails++;
      $error("exit_o nonzero outside an exit write");
    end

endmodule

bind soc_mem_top soc_mem_props soc_mem_props_inst (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .req_i       ( req_i       ),
  .we_i        ( we_i        ),
  .addr_i      ( addr_i      ),
  .rsp_valid_i ( rsp_valid_o ),
  .rdata_i     ( rdata_o     ),
  .err_i       ( err_o       ),
  .exit_i      ( exit_o      )
);

/* soc_mem_checker.sv */
// Response checker with exit value in the request cycle and answer one cycle later
module soc_mem_checker
  import soc_mem_pkg::*;
(
  input  logic         clk_i,
  input  logic         req_i,
  input  logic [127:0] name_i,
  input  data_t        exp_rdata_i,
  input  logic         exp_err_i,
  input  logic [31:0]  exp_exit_i,
  input  logic         rsp_valid_i,
  input  data_t        rdata_i,
  input  logic         err_i,
  input  logic [31:0]  exit_i,
  output int unsigned  tests_o,
  output int unsigned  errors_o
);

  logic         pend_q;
  logic [127:0] pend_name;
  data_t        pend_rdata;
  logic         pend_err;
  logic         exit_bad;
  logic [31:0]  exit_seen;
  logic [31:0]  exit_want;

  initial begin
    tests_o  = 0;
    errors_o = 0;
    pend_q   = 1'b0;
    exit_bad = 1'b0;
  end

  // Sampled mid-cycle where inputs and registered outputs have settled
  always @(negedge clk_i) begin
    if (pend_q) begin
      tests_o++;
      if (rsp_valid_i !== 1'b1) begin
        errors_o++;
        $display("No response arrived for %s at time %0t", pend_name, $time);
      end else if (exit_bad) begin
        errors_o++;
        $display("ERR %0t %s: exit_o %h, expected %h", $time, pend_name, exit_seen, exit_want);
      end else if (err_i !== pend_err) begin
        errors_o++;
        $display("ERR %0t %s: err_o %b, expected %b", $time, pend_name, err_i, pend_err);
      end else if (rdata_i !== pend_rdata) begin
        errors_o++;
        $display("ERR %0t %s: rdata_o %h, expected %h", $time, pend_name, rdata_i, pend_rdata);
      end else begin
        $display("PASS %s", pend_name);
      end
    end else if (rsp_valid_i !== 1'b0 || err_i !== 1'b0) begin
      errors_o++;
      $display("Response seen at time %0t with no request outstanding", $time);
    end
    // Capture the request of this cycle
    pend_q = req_i;
    if (req_i) begin
      pend_name  = name_i;
      pend_rdata = exp_rdata_i;
      pend_err   = exp_err_i;
      exit_seen  = exit_i;
      exit_want  = exp_exit_i;
      exit_bad   = (exit_i !== exp_exit_i);
    end else if (exit_i !== 32'h0) begin
      errors_o++;
      $display("ERR %0t exit_o %h while no request is on the bus", $time, exit_i);
    end
  end

endmodule

/* soc_mem_tb.sv */
// Testbench top with clock, reset, stimulus table, LFSR data, watchdog and summary
`include "soc_mem_config.svh"

module soc_mem_tb
  import soc_mem_pkg::*;
();

  localparam int clk_period  = 100;
  localparam int drive_delay = 10;

  typedef struct packed {
    logic [127:0] name;
    logic         req;
    logic         we;
    logic [31:0]  addr;
    strb_t        be;
    data_t        wdata;
    logic         rnd;
    logic         use_shadow;
    data_t        exp_rdata;
    logic         exp_err;
    logic [31:0]  exp_exit;
  } entry_t;

  logic         clk;
  logic         rst_n;
  logic         req;
  logic         we;
  bus_addr_u    addr;
  strb_t        be;
  data_t        wdata;
  logic         rsp_valid;
  data_t        rdata;
  logic         err;
  logic [31:0]  exit_val;
  logic [127:0] exp_name;
  data_t        exp_rdata;
  logic         exp_err;
  logic [31:0]  exp_exit;
  int unsigned  tests_done;
  int unsigned  errors;
  int unsigned  req_count;
  logic         table_ready;
  logic [31:0]  lfsr_state;
  data_t        shadow_mem [`SOC_SRAM_WORDS];
  entry_t       stim_q [$];

  soc_mem_top soc_mem_top_inst (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .req_i       ( req       ),
    .we_i        ( we        ),
    .addr_i      ( addr      ),
    .be_i        ( be        ),
    .wdata_i     ( wdata     ),
    .rsp_valid_o ( rsp_valid ),
    .rdata_o     ( rdata     ),
    .err_o       ( err       ),
    .exit_o      ( exit_val  )
  );

  soc_mem_checker checker_inst (
    .clk_i       ( clk        ),
    .req_i       ( req        ),
    .name_i      ( exp_name   ),
    .exp_rdata_i ( exp_rdata  ),
    .exp_err_i   ( exp_err    ),
    .exp_exit_i  ( exp_exit   ),
    .rsp_valid_i ( rsp_valid  ),
    .rdata_i     ( rdata      ),
    .err_i       ( err        ),
    .exit_i      ( exit_val   ),
    .tests_o     ( tests_done ),
    .errors_o    ( errors     )
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Galois LFSR stepped once per data bit
  function automatic data_t lfsr_data();
    data_t value;
    value = '0;
    for (int i = 0; i < `SOC_DATA_W; i++) begin
      value = {value[`SOC_DATA_W-2:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return value;
  endfunction

  task automatic add_entry(input logic [127:0] name, input logic rq, input logic wr,
                           input logic [31:0] a, input strb_t b, input data_t d,
                           input logic rnd, input logic sh, input data_t rd,
                           input logic er, input logic [31:0] ex);
    stim_q.push_back('{name, rq, wr, a, b, d, rnd, sh, rd, er, ex});
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  task automatic build_table();
    add_entry("idle_start", 0, 0, 32'h0, 8'h00, 64'h0, 0, 0, 64'h0, 0, 32'h0);
    add_entry("wr_full", 1, 1, 32'h8000_0010, 8'hff, 64'h1122_3344_5566_7788, 0, 0, 64'h0, 0, 0);
    add_entry("rd_full", 1, 0, 32'h8000_0010, 8'h00, 64'h0, 0, 0, 64'h1122_3344_5566_7788, 0, 0);
    add_entry("rd_wrap", 1, 0, 32'h8000_2010, 8'h00, 64'h0, 0, 0, 64'h1122_3344_5566_7788, 0, 0);
    add_entry("wr_rnd", 1, 1, 32'h8000_0100, 8'hff, 64'h0, 1, 0, 64'h0, 0, 32'h0);
    add_entry("rd_rnd", 1, 0, 32'h8000_0100, 8'h00, 64'h0, 0, 1, 64'h0, 0, 32'h0);
    add_entry("rd_rnd_wrap", 1, 0, 32'h8000_2100, 8'h00, 64'h0, 0, 1, 64'h0, 0, 32'h0);
    add_entry("wr_part", 1, 1, 32'h8000_0010, 8'h0f, 64'hAABB_CCDD_EEFF_0011, 0, 0, 64'h0, 0, 0);
    add_entry("rd_part", 1, 0, 32'h8000_0010, 8'h00, 64'h0, 0, 0, 64'h1122_3344_EEFF_0011, 0, 0);
    add_entry("wr_rnd_part", 1, 1, 32'h8000_0100, 8'hf0, 64'hA5A5_A5A5_0000_0000, 0, 0, 0, 0, 0);
    add_entry("rd_rnd_part", 1, 0, 32'h8000_0100, 8'h00, 64'h0, 0, 1, 64'h0, 0, 32'h0);
    add_entry("rd_rom0", 1, 0, 32'h0001_0000, 8'h00, 64'h0, 0, 0, 64'hB007_0000_4FF8_FFFF, 0, 0);
    add_entry("rd_rom5", 1, 0, 32'h0001_0028, 8'h00, 64'h0, 0, 0, 64'hB007_0005_4FF8_FFFA, 0, 0);
    add_entry("wr_rom", 1, 1, 32'h0001_0028, 8'hff, 64'hDEAD_BEEF_DEAD_BEEF, 0, 0, 64'h0, 0, 0);
    add_entry("rd_rom5_again", 1, 0, 32'h0001_0028, 8'h00, 0, 0, 0, 64'hB007_0005_4FF8_FFFA, 0, 0);
    add_entry("rd_rom_wrap", 1, 0, 32'h0001_0088, 8'h00, 64'h0, 0, 0, 64'hB007_0001_4FF8_FFFE, 0, 0);
    add_entry("rd_unmap", 1, 0, 32'h4000_0010, 8'h00, 64'h0, 0, 0, 64'h0, 1, 32'h0);
    add_entry("wr_unmap", 1, 1, 32'h4000_0010, 8'hff, 64'hFFFF_FFFF_FFFF_FFFF, 0, 0, 64'h0, 1, 0);
    add_entry("rd_after_err", 1, 0, 32'h8000_0010, 8'h00, 0, 0, 0, 64'h1122_3344_EEFF_0011, 0, 0);
    add_entry("wr_exit", 1, 1, 32'h8000_1FF8, 8'hff, 64'h0000_0001_CAFE_F00D, 0, 0, 0, 0,
              32'hCAFE_F00D);
    add_entry("rd_exit", 1, 0, 32'h8000_1FF8, 8'h00, 64'h0, 0, 0, 64'h0000_0001_CAFE_F00D, 0, 0);
    add_entry("wr_exit_alias", 1, 1, 32'h8000_3FF8, 8'hff, 64'h0000_0002_1234_5678, 0, 0, 0, 0, 0);
    add_entry("rd_exit_alias", 1, 0, 32'h8000_1FF8, 8'h00, 0, 0, 0, 64'h0000_0002_1234_5678, 0, 0);
    add_entry("idle_end", 0, 0, 32'h0, 8'h00, 64'h0, 0, 0, 64'h0, 0, 32'h0);
  endtask

  // Shadow model tracks SRAM writes for LFSR-based expectations
  task automatic apply_entry(input entry_t e);
    data_t      data;
    data_t      expect_rd;
    logic [9:0] idx;
    data = e.wdata;
    if (e.rnd) begin
      data = lfsr_data();
    end
    idx       = e.addr[12:3];
    expect_rd = e.use_shadow ? shadow_mem[idx] : e.exp_rdata;
    if (e.req && e.we && e.addr[31:16] == `SOC_DRAM_TAG) begin
      for (int b = 0; b < `SOC_STRB_W; b++) begin
        if (e.be[b]) begin
          shadow_mem[idx][b*8 +: 8] = data[b*8 +: 8];
        end
      end
    end
    @(posedge clk);
    #drive_delay;
    req       = e.req;
    we        = e.we;
    addr      = e.addr;
    be        = e.be;
    wdata     = data;
    exp_name  = e.name;
    exp_rdata = expect_rd;
    exp_err   = e.exp_err;
    exp_exit  = e.exp_exit;
    if (e.req) begin
      req_count++;
    end
  endtask

  // ----------------------------------------
  // Main sequence and summary
  // ----------------------------------------
  initial begin
    rst_n       = 1'b0;
    req         = 1'b0;
    we          = 1'b0;
    addr        = '0;
    be          = '0;
    wdata       = '0;
    exp_name    = '0;
    exp_rdata   = '0;
    exp_err     = 1'b0;
    exp_exit    = '0;
    req_count   = 0;
    lfsr_state  = 32'd89;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;
    foreach (stim_q[i]) begin
      apply_entry(stim_q[i]);
    end
    wait (tests_done == req_count);
    @(negedge clk);
    $display("Summary: %0d tests, %0d errors, %0d assertion failures", tests_done, errors,
             soc_mem_top_inst.soc_mem_props_inst.assert_fails);
    if (errors == 0 && soc_mem_top_inst.soc_mem_props_inst.assert_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    wait (table_ready);
    #((stim_q.size() + 20) * clk_period);
    $display("Timeout: the run did not finish within %0d cycles", stim_q.size() + 20);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* soc_mem.f */
+incdir+.
soc_mem_pkg.sv
addr_decoder.sv
sram_bank.sv
boot_rom.sv
bus_response_mux.sv
soc_mem_top.sv
soc_mem_props.sv
soc_mem_checker.sv
soc_mem_tb.sv
